/* flist.f */
design/lsu_pkg.sv
design/lsu_req_gen.sv
design/lsu_txn_ctrl.sv
design/lsu_rdata_align.sv
design/lsu_top.sv
verification/lsu_mem_model.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - design/lsu_pkg.sv
  - design/lsu_req_gen.sv
  - design/lsu_txn_ctrl.sv
  - design/lsu_rdata_align.sv
  - design/lsu_top.sv
  - target: test
    files:
      - verification/lsu_mem_model.sv
      - verification/lsu_tb.sv

/* verification/lsu_tb.sv */
// Load/store unit testbench: clock, reset, stimulus table, reference memory, checks, report

`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam logic [LSU_XLEN-1:0] ERR_LO  = 32'h0000_00E0;
  localparam logic [LSU_XLEN-1:0] ERR_HI  = 32'h0000_00EF;
  localparam int unsigned         SEED    = 32'h98710e5e;
  // Cycles allowed for any single wait
  localparam int                  TIMEOUT = 200;

  typedef struct packed {
    lsu_size_e            size;
    logic                 we;
    logic                 sx;
    logic [LSU_XLEN-1:0]  a;
    logic [LSU_XLEN-1:0]  b;
    logic [LSU_XLEN-1:0]  wdata;
    logic [LSU_XLEN-1:0]  exp_rdata;
    logic                 exp_err;
  } row_t;

  logic clk;
  logic rst_n;
  logic valid_0;
  lsu_size_e size;
  logic we;
  logic sign_ext;
  logic [LSU_XLEN-1:0] op_a;
  logic [LSU_XLEN-1:0] op_b;
  logic [LSU_XLEN-1:0] wdata;
  logic ready_0;
  logic split_0;
  logic data_req;
  logic data_gnt;
  logic [LSU_XLEN-1:0] data_addr;
  logic data_we;
  logic [LSU_BE_W-1:0] data_be;
  logic [LSU_XLEN-1:0] data_wdata;
  logic data_rvalid;
  logic [LSU_XLEN-1:0] data_rdata;
  logic data_err;
  logic valid_1;
  logic [LSU_XLEN-1:0] rdata_1;
  logic err_1;
  logic busy;

  row_t rows [$];
  // Reference copy of the memory updated in program order
  logic [7:0] ref_mem [256];
  int n_checks;
  int n_errors;
  int n_valid;
  int outstanding;
  logic err_seen;

  lsu_top i_lsu_top (
    .clk (clk), .rst_n (rst_n),
    .valid_0_i (valid_0), .size_i (size), .we_i (we), .sign_ext_i (sign_ext),
    .op_a_i (op_a), .op_b_i (op_b), .wdata_i (wdata),
    .ready_0_o (ready_0), .split_0_o (split_0),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_addr_o (data_addr),
    .data_we_o (data_we), .data_be_o (data_be), .data_wdata_o (data_wdata),
    .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata), .data_err_i (data_err),
    .valid_1_o (valid_1), .rdata_1_o (rdata_1), .err_1_o (err_1), .busy_o (busy)
  );

  lsu_mem_model #(.ERR_LO (ERR_LO), .ERR_HI (ERR_HI), .SEED (SEED)) i_mem (
    .clk (clk), .rst_n (rst_n), .req_i (data_req), .gnt_o (data_gnt),
    .addr_i (data_addr), .we_i (data_we), .be_i (data_be), .wdata_i (data_wdata),
    .rvalid_o (data_rvalid), .rdata_o (data_rdata), .err_o (data_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input logic [LSU_XLEN-1:0] got, input logic [LSU_XLEN-1:0] exp,
                             input string msg);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic int access_bytes(input lsu_size_e sz);
    return (sz == LSU_BYTE) ? 1 : ((sz == LSU_HALF) ? 2 : 4);
  endfunction

  function automatic logic in_err_window(input logic [LSU_XLEN-1:0] addr);
    logic [LSU_XLEN-1:0] wa;
    wa = addr & ~32'h3;
    return (wa >= ERR_LO) && (wa <= ERR_HI);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  // Expected load data and errors come from the reference memory at build time
  task automatic add_access(input lsu_size_e sz, input logic st, input logic sx,
                            input logic [LSU_XLEN-1:0] ea, input logic [LSU_XLEN-1:0] wd);
    row_t r;
    int   nb;
    nb          = access_bytes(sz);
    r.size      = sz;
    r.we        = st;
    r.sx        = sx;
    // Spread the address over both operands
    r.b         = (rows.size() * 5) & 32'h3F;
    r.a         = ea - r.b;
    r.wdata     = wd;
    r.exp_rdata = '0;
    r.exp_err   = in_err_window(ea) || in_err_window(ea + nb - 1);
    for (int j = 0; j < nb; j++)
    begin
      if (st && !in_err_window(ea + j))
      begin
        ref_mem[(ea + j) & 32'hFF] = wd[8*j +: 8];
      end
      r.exp_rdata[8*j +: 8] = ref_mem[(ea + j) & 32'hFF];
    end
    if (st)
    begin
      r.exp_rdata = '0;
    end
    else if (sx && nb == 1)
    begin
      r.exp_rdata[31:8] = {24{r.exp_rdata[7]}};
    end
    else if (sx && nb == 2)
    begin
      r.exp_rdata[31:16] = {16{r.exp_rdata[15]}};
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [LSU_XLEN-1:0] base;
    for (int k = 0; k < 256; k++)
    begin
      ref_mem[k] = 8'(k * 8'h3B);
    end
    // Aligned loads, unsigned and signed
    for (int s = 0; s < 2; s++)
    begin
      add_access(LSU_BYTE, 1'b0, s[0], 32'h11, '0);
      add_access(LSU_HALF, 1'b0, s[0], 32'h24, '0);
      add_access(LSU_WORD, 1'b0, s[0], 32'h30, '0);
    end
    // Every size at every offset, then both words it may touch
    for (int sz = 0; sz < 3; sz++)
    begin
      for (int ofs = 0; ofs < 4; ofs++)
      begin
        base = 32'h40 + sz * 32'h20 + ofs * 8;
        add_access(lsu_size_e'(sz), 1'b1, 1'b0, base + ofs,
                   32'h8E71_D4B0 + sz * 32'h1111 + ofs * 32'h0101_0101);
        add_access(LSU_WORD, 1'b0, 1'b0, base, '0);
        add_access(LSU_WORD, 1'b0, 1'b0, base + 4, '0);
      end
    end
    // Misaligned loads
    add_access(LSU_WORD, 1'b0, 1'b0, 32'h81, '0);
    add_access(LSU_WORD, 1'b0, 1'b0, 32'h86, '0);
    add_access(LSU_WORD, 1'b0, 1'b0, 32'h8B, '0);
    add_access(LSU_HALF, 1'b0, 1'b1, 32'h93, '0);
    // Mixed back-to-back traffic
    for (int k = 0; k < 16; k++)
    begin
      add_access(lsu_size_e'(k % 3), (k % 4) == 1, k[0], 32'hA0 + k * 3,
                 32'h5A3C_0000 + k * 32'h0001_0111);
    end
    // Error window, split with error in either phase, then normal loads
    add_access(LSU_WORD, 1'b0, 1'b0, 32'hE4, '0);
    add_access(LSU_WORD, 1'b0, 1'b0, 32'hDE, '0);
    add_access(LSU_WORD, 1'b0, 1'b0, 32'hEE, '0);
    add_access(LSU_WORD, 1'b0, 1'b0, 32'h30, '0);
    add_access(LSU_BYTE, 1'b0, 1'b1, 32'h11, '0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response monitor
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    err_seen    = 1'b0;
    n_valid     = 0;
    outstanding = 0;
    forever
    begin
      @(negedge clk);
      if (rst_n)
      begin
        // Tracked count still equals the DUT counter before this cycle updates it
        check_value(busy, (outstanding != 0) || valid_0, "busy while accesses are pending");
        if (data_rvalid)
        begin
          outstanding--;
        end
        if (data_req && data_gnt)
        begin
          outstanding++;
          check_value(outstanding <= int'(LSU_DEPTH), 1'b1, "outstanding transfers");
        end
        // Error of a first split phase belongs to the same instruction
        if (err_1)
        begin
          err_seen = 1'b1;
        end
        if (valid_1)
        begin
          if (n_valid < rows.size())
          begin
            if (!rows[n_valid].we)
            begin
              check_value(rdata_1, rows[n_valid].exp_rdata, $sformatf("rdata access %0d", n_valid));
            end
            check_value(err_seen, rows[n_valid].exp_err, $sformatf("error access %0d", n_valid));
          end
          else
          begin
            n_errors++;
            $display("Unexpected valid_1_o pulse after the last access at %0t", $time);
          end
          n_valid++;
          err_seen = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Driver
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int                  wait_cnt;
    int                  n_xfer;
    logic                done;
    logic                timed_out;
    logic                exp_split;
    logic [LSU_XLEN-1:0] ea;
    n_checks  = 0;
    n_errors  = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    valid_0   = 1'b0;
    size      = LSU_BYTE;
    we        = 1'b0;
    sign_ext  = 1'b0;
    op_a      = '0;
    op_b      = '0;
    wdata     = '0;
    build_table();
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_value({data_req, ready_0, valid_1, err_1, busy, split_0}, '0, "outputs in reset");
    @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < rows.size() && !timed_out; i++)
    begin
      @(posedge clk);
      valid_0  <= 1'b1;
      size     <= rows[i].size;
      we       <= rows[i].we;
      sign_ext <= rows[i].sx;
      op_a     <= rows[i].a;
      op_b     <= rows[i].b;
      wdata    <= rows[i].wdata;
      ea        = rows[i].a + rows[i].b;
      exp_split = (rows[i].size == LSU_WORD && ea[1:0] != 2'd0) ||
                  (rows[i].size == LSU_HALF && ea[1:0] == 2'd3);
      n_xfer    = 0;
      wait_cnt  = 0;
      done      = 1'b0;
      while (!done && wait_cnt < TIMEOUT)
      begin
        @(negedge clk);
        wait_cnt++;
        if (data_req && data_gnt)
        begin
          if (n_xfer == 0)
          begin
            check_value(data_addr, ea, $sformatf("first address access %0d", i));
            check_value(split_0, exp_split, $sformatf("split flag access %0d", i));
          end
          else
          begin
            // Second phase goes to the next word
            check_value(data_addr, (ea & ~32'h3) + 4, $sformatf("second address access %0d", i));
          end
          n_xfer++;
        end
        if (ready_0)
        begin
          done = 1'b1;
        end
      end
      if (!done)
      begin
        n_errors++;
        timed_out = 1'b1;
        $display("Timed out waiting for ready_0_o on access %0d", i);
      end
      else
      begin
        check_value(n_xfer, exp_split ? 2 : 1, $sformatf("bus transfers access %0d", i));
      end
    end
    @(posedge clk);
    valid_0 <= 1'b0;

    wait_cnt = 0;
    while (!timed_out && n_valid < rows.size() && wait_cnt < TIMEOUT)
    begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!timed_out && n_valid < rows.size())
    begin
      n_errors++;
      timed_out = 1'b1;
      $display("Timed out waiting for responses, %0d of %0d seen", n_valid, rows.size());
    end
    if (!timed_out)
    begin
      repeat (2) @(negedge clk);
      check_value(busy, 1'b0, "busy after last response");
      check_value(n_valid, rows.size(), "valid_1_o pulse count");
    end

    $display("Accesses: %0d, checks: %0d, errors: %0d", rows.size(), n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* verification/lsu_mem_model.sv */
// Data bus memory model: byte array, random grant stalls, in-order random response latency, error window

`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*;
#(
  // Word addresses in [ERR_LO, ERR_HI] answer with an error
  parameter logic [LSU_XLEN-1:0] ERR_LO    = '0,
  parameter logic [LSU_XLEN-1:0] ERR_HI    = '0,
  parameter int unsigned         SEED      = 0,
  parameter int unsigned         MEM_BYTES = 256
)
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_i,
  output logic                  gnt_o,
  input  logic [LSU_XLEN-1:0]   addr_i,
  input  logic                  we_i,
  input  logic [LSU_BE_W-1:0]   be_i,
  input  logic [LSU_XLEN-1:0]   wdata_i,
  output logic                  rvalid_o,
  output logic [LSU_XLEN-1:0]   rdata_o,
  output logic                  err_o
);

  logic [7:0]           mem [MEM_BYTES];
  logic                 gnt_en_q;

  // Pending responses, oldest first
  logic [LSU_XLEN-1:0]  rdata_q [$];
  logic                 err_q [$];
  int                   due_q [$];

  int                   cycle;
  int                   last_due;

  // Grant only in cycles the random stall lets through
  assign gnt_o = req_i && gnt_en_q;

  initial
  begin
    logic [LSU_XLEN-1:0] wa;
    logic [LSU_XLEN-1:0] word;
    logic                hit;
    int                  due;
    void'($urandom(SEED));
    // Fill pattern, low byte of address times 0x3B
    for (int k = 0; k < MEM_BYTES; k++)
    begin
      mem[k] = 8'(k * 8'h3B);
    end
    gnt_en_q = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    cycle    = 0;
    last_due = 0;
    forever
    begin
      @(posedge clk);
      cycle++;
      if (!rst_n)
      begin
        gnt_en_q <= 1'b0;
        rvalid_o <= 1'b0;
      end
      else
      begin
        // Transfer granted in the cycle that just ended
        if (req_i && gnt_o)
        begin
          wa  = {addr_i[LSU_XLEN-1:2], 2'b00};
          hit = (wa >= ERR_LO) && (wa <= ERR_HI);
          for (int l = 0; l < LSU_BE_W; l++)
          begin
            // Stores into the error window are dropped
            if (we_i && be_i[l] && !hit)
            begin
              mem[(wa + l) % MEM_BYTES] = wdata_i[8*l +: 8];
            end
            word[8*l +: 8] = mem[(wa + l) % MEM_BYTES];
          end
          // Earliest response is the cycle right after the grant
          due = cycle + $urandom_range(0, 3);
          if (due <= last_due)
          begin
            due = last_due + 1;
          end
          last_due = due;
          rdata_q.push_back(word);
          err_q.push_back(hit);
          due_q.push_back(due);
        end
        // One response per cycle, in grant order
        if (due_q.size() > 0 && due_q[0] <= cycle)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= rdata_q.pop_front();
          err_o    <= err_q.pop_front();
          void'(due_q.pop_front());
        end
        else
        begin
          rvalid_o <= 1'b0;
          err_o    <= 1'b0;
        end
        // Grant three cycles out of four on average
        gnt_en_q <= ($urandom_range(0, 3) != 0);
      end
    end
  end

endmodule

/* design/lsu_top.sv */
// Load/store unit top level: request generator, transfer control and load data alignment

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // EX side, held stable until ready_0_o
  input  logic                  valid_0_i,
  input  lsu_size_e             size_i,
  input  logic                  we_i,
  input  logic                  sign_ext_i,
  input  logic [LSU_XLEN-1:0]   op_a_i,
  input  logic [LSU_XLEN-1:0]   op_b_i,
  input  logic [LSU_XLEN-1:0]   wdata_i,
  output logic                  ready_0_o,
  output logic                  split_0_o,

  // Data bus, request channel
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  output logic [LSU_XLEN-1:0]   data_addr_o,
  output logic                  data_we_o,
  output logic [LSU_BE_W-1:0]   data_be_o,
  output logic [LSU_XLEN-1:0]   data_wdata_o,

  // Data bus, response channel
  input  logic                  data_rvalid_i,
  input  logic [LSU_XLEN-1:0]   data_rdata_i,
  input  logic                  data_err_i,

  // WB side
  output logic                  valid_1_o,
  output logic [LSU_XLEN-1:0]   rdata_1_o,
  output logic                  err_1_o,
  output logic                  busy_o
);

  // Grant of the current address phase
  logic                  accept;
  logic [LSU_OFS_W-1:0]  phase_offset;
  // Oldest outstanding transfer
  lsu_wb_ctrl_t          head;

  // Write enable goes straight to the bus
  assign data_we_o = we_i;

  lsu_req_gen i_lsu_req_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (valid_0_i),
    .size_i    (size_i),
    .we_i      (we_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .wdata_i   (wdata_i),
    .accept_i  (accept),
    .addr_o    (data_addr_o),
    .be_o      (data_be_o),
    .wdata_o   (data_wdata_o),
    .split_o   (split_0_o),
    .offset_o  (phase_offset)
  );

  lsu_txn_ctrl i_lsu_txn_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_0_i),
    .split_i    (split_0_o),
    .size_i     (size_i),
    .we_i       (we_i),
    .sign_ext_i (sign_ext_i),
    .offset_i   (phase_offset),
    .gnt_i      (data_gnt_i),
    .rvalid_i   (data_rvalid_i),
    .err_i      (data_err_i),
    .req_o      (data_req_o),
    .accept_o   (accept),
    .ready_o    (ready_0_o),
    .busy_o     (busy_o),
    .head_o     (head),
    .valid_1_o  (valid_1_o),
    .err_1_o    (err_1_o)
  );

  lsu_rdata_align i_lsu_rdata_align (
    .clk       (clk),
    .rst_n     (rst_n),
    .rvalid_i  (data_rvalid_i),
    .rdata_i   (data_rdata_i),
    .head_i    (head),
    .rdata_o   (rdata_1_o)
  );

endmodule

/* design/lsu_rdata_align.sv */
// Load data alignment: split word assembly, byte and halfword selection, sign or zero extension

`timescale 1ns/1ps

module lsu_rdata_align import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // Bus response
  input  logic                  rvalid_i,
  input  logic [LSU_XLEN-1:0]   rdata_i,

  // Control of the transfer being answered
  input  lsu_wb_ctrl_t          head_i,

  // Aligned and extended load data
  output logic [LSU_XLEN-1:0]   rdata_o
);

  // Word returned by the first phase of a split load
  logic [LSU_XLEN-1:0]     rdata_q;

  // Current response is the second half of a split access
  logic                    split_resp;

  // Two words side by side, shifted down to the offset
  logic [2*LSU_XLEN-1:0]   window;
  logic [LSU_XLEN-1:0]     word;

  //////////////////////////////////////////////////////////////////////
  // First-phase data
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (rvalid_i && !head_i.last && !head_i.we)
    begin
      rdata_q <= rdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Alignment
  //////////////////////////////////////////////////////////////////////

  // Same rule as in the request generator, applied to the stored offset
  always_comb
  begin
    case (head_i.size)
      LSU_WORD: split_resp = (head_i.offset != '0);
      LSU_HALF: split_resp = (head_i.offset == '1);
      default:  split_resp = 1'b0;
    endcase
  end

  // Split: upper bytes of the first word, then low bytes of the second
  // Otherwise a plain rotate right of the response by the offset
  assign window = {rdata_i, (split_resp ? rdata_q : rdata_i)} >> {head_i.offset, 3'b000};
  assign word   = window[LSU_XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // Extension
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (head_i.size)
      LSU_BYTE:
      begin
        rdata_o = {{(LSU_XLEN-8){head_i.sign_ext & word[7]}}, word[7:0]};
      end
      LSU_HALF:
      begin
        rdata_o = {{(LSU_XLEN-16){head_i.sign_ext & word[15]}}, word[15:0]};
      end
      default:
      begin
        rdata_o = word;
      end
    endcase
  end

endmodule

/* design/lsu_txn_ctrl.sv */
// Transfer control: outstanding counter, request and ready, response control queue, WB outputs

`timescale 1ns/1ps

module lsu_txn_ctrl import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // EX side
  input  logic                  valid_i,
  input  logic                  split_i,
  input  lsu_size_e             size_i,
  input  logic                  we_i,
  input  logic                  sign_ext_i,
  input  logic [LSU_OFS_W-1:0]  offset_i,

  // Bus handshake
  input  logic                  gnt_i,
  input  logic                  rvalid_i,
  input  logic                  err_i,

  output logic                  req_o,
  output logic                  accept_o,
  output logic                  ready_o,
  output logic                  busy_o,

  // Control of the oldest outstanding transfer
  output lsu_wb_ctrl_t          head_o,

  // WB side
  output logic                  valid_1_o,
  output logic                  err_1_o
);

  // Granted transfers still waiting for rvalid
  logic [LSU_CNT_W-1:0]  cnt_q;
  logic [LSU_CNT_W-1:0]  cnt_d;

  // In-order queue with one entry per outstanding transfer
  lsu_wb_ctrl_t          queue_q [LSU_DEPTH];
  lsu_wb_ctrl_t          push_entry;

  // One bit pointers into the two entries
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // At full count a response in this cycle frees a slot for a new request
  assign req_o    = valid_i && ((cnt_q < LSU_DEPTH) || rvalid_i);
  assign accept_o = req_o && gnt_i;

  // EX is done once its last address phase is granted
  assign ready_o  = accept_o && !split_i;

  // Something in flight or about to be
  assign busy_o   = (cnt_q != '0) || req_o;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  // A grant at full count always comes with a response, so LSU_DEPTH is the top
  always_comb
  begin
    case ({accept_o, rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response-stage control queue
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    push_entry.size     = size_i;
    push_entry.sign_ext = sign_ext_i;
    push_entry.we       = we_i;
    push_entry.offset   = offset_i;
    // First phase of a split is never the last transfer
    push_entry.last     = !split_i;
  end

  // Write pointer steps on each push, read pointer on each pop
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end
    else
    begin
      if (accept_o)
      begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (rvalid_i)
      begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  // At full count a push lands in the slot popped in the same cycle
  always_ff @(posedge clk)
  begin
    if (accept_o)
    begin
      queue_q[wr_ptr_q] <= push_entry;
    end
  end

  assign head_o = queue_q[rd_ptr_q];

  //////////////////////////////////////////////////////////////////////
  // WB outputs
  //////////////////////////////////////////////////////////////////////

  // One valid per instruction with the response of its last transfer
  assign valid_1_o = rvalid_i && head_o.last;

  // Errors are flagged on any response including a first split phase
  assign err_1_o   = rvalid_i && err_i;

endmodule

/* design/lsu_req_gen.sv */
// Request generator: address adder, split detection, phase register, byte enables, store rotation

`timescale 1ns/1ps

module lsu_req_gen import lsu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // EX side instruction
  input  logic                  valid_i,
  input  lsu_size_e             size_i,
  input  logic                  we_i,
  input  logic [LSU_XLEN-1:0]   op_a_i,
  input  logic [LSU_XLEN-1:0]   op_b_i,
  input  logic [LSU_XLEN-1:0]   wdata_i,

  // Current address phase granted on the bus
  input  logic                  accept_i,

  // Request fields
  output logic [LSU_XLEN-1:0]   addr_o,
  output logic [LSU_BE_W-1:0]   be_o,
  output logic [LSU_XLEN-1:0]   wdata_o,

  // First phase of a misaligned access that needs a second transfer
  output logic                  split_o,
  // Byte offset of the access in both phases
  output logic [LSU_OFS_W-1:0]  offset_o
);

  // High during the second address phase of a split access
  logic                      phase_q;

  logic [LSU_XLEN-1:0]       addr_sum;
  logic [LSU_OFS_W-1:0]      ofs;

  // Lanes of the access before shifting to its offset
  logic [LSU_BE_W-1:0]       be_base;
  // Lanes spread over two words with the second phase on top
  logic [2*LSU_BE_W-1:0]     be_wide;

  // Store data twice for rotation by shifting
  logic [2*LSU_XLEN-1:0]     wdata_dbl;

  //////////////////////////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////////////////////////

  // Second phase goes to the next word, so add four on top of the operands
  assign addr_sum = op_a_i + op_b_i + {{(LSU_XLEN-3){1'b0}}, phase_q, 2'b00};

  // Adding four keeps the low bits, so the offset is valid in both phases
  assign ofs      = addr_sum[LSU_OFS_W-1:0];
  assign offset_o = ofs;

  // Second phase is issued word aligned, its lanes start at byte 0
  assign addr_o = phase_q ? {addr_sum[LSU_XLEN-1:LSU_OFS_W], {LSU_OFS_W{1'b0}}} : addr_sum;

  //////////////////////////////////////////////////////////////////////
  // Split detection and phase tracking
  //////////////////////////////////////////////////////////////////////

  // Word at any nonzero offset or halfword crossing into the next word
  always_comb
  begin
    split_o = 1'b0;
    if (valid_i && !phase_q)
    begin
      case (size_i)
        LSU_WORD: split_o = (ofs != '0);
        LSU_HALF: split_o = (ofs == '1);
        default:  split_o = 1'b0;
      endcase
    end
  end

  // Cleared while no instruction is presented, so a new one starts in phase one
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase_q <= 1'b0;
    end
    else if (!valid_i)
    begin
      phase_q <= 1'b0;
    end
    else if (accept_i)
    begin
      // First grant of a split moves on and the second grant returns to idle
      phase_q <= split_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (size_i)
      LSU_BYTE: be_base = LSU_BE_W'(1);
      LSU_HALF: be_base = LSU_BE_W'(3);
      default:  be_base = '1;
    endcase
  end

  // Shift lanes to the offset; lanes pushed past byte 3 belong to the next word
  assign be_wide = {{LSU_BE_W{1'b0}}, be_base} << ofs;

  assign be_o = phase_q ? be_wide[2*LSU_BE_W-1:LSU_BE_W] : be_wide[LSU_BE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Store data
  //////////////////////////////////////////////////////////////////////

  // Rotate left by the byte offset
  // Bytes wrapped into the low lanes are the ones the second phase writes
  assign wdata_dbl = {wdata_i, wdata_i} << {ofs, 3'b000};

  // Loads put zero on the write data lines
  assign wdata_o = we_i ? wdata_dbl[2*LSU_XLEN-1:LSU_XLEN] : '0;

endmodule

/* design/lsu_pkg.sv */
// Load/store unit shared widths, outstanding depth, access size enum and response-stage control

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and address width
  localparam int unsigned LSU_XLEN  = 32;

  // Byte lanes per bus word
  localparam int unsigned LSU_BE_W  = LSU_XLEN / 8;

  // Byte offset inside a word
  localparam int unsigned LSU_OFS_W = $clog2(LSU_BE_W);

  //////////////////////////////////////////////////////////////////////
  // Outstanding transfers
  //////////////////////////////////////////////////////////////////////

  // Max bus transfers granted but not yet answered
  localparam int unsigned LSU_DEPTH = 2;

  // Counter must hold 0 up to LSU_DEPTH
  localparam int unsigned LSU_CNT_W = $clog2(LSU_DEPTH + 1);

  //////////////////////////////////////////////////////////////////////
  // Access size and response-stage control
  //////////////////////////////////////////////////////////////////////

  // Encoding follows the funct3 size field of RISC-V loads and stores
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Travels with each granted transfer until its response comes back
  typedef struct packed {
    // Access size of the instruction
    lsu_size_e              size;
    // Sign extend byte and halfword loads
    logic                   sign_ext;
    // Store, response carries no load data
    logic                   we;
    // Byte offset of the original address
    logic [LSU_OFS_W-1:0]   offset;
    // Low only for the first transfer of a split access
    logic                   last;
  } lsu_wb_ctrl_t;

endpackage
